// ==== build.f ====
source/bus_pkg.sv
source/addr_map_pkg.sv
source/region_decoder.sv
source/response_merge.sv
source/test_mailbox.sv
source/dbus_router.sv
verification/tb_clock_gen.sv
verification/dbus_router_checker.sv
verification/dbus_router_tb.sv

// ==== verification/dbus_router_tb.sv ====
// ########################################
// Router testbench: core-side requests,
// random target responses, mailbox writes
// ########################################

module dbus_router_tb;

  import bus_pkg::*;
  import addr_map_pkg::*;

  localparam int unsigned periph_sel_bit = 20;
  localparam int unsigned drive_delay    = 2;
  localparam int unsigned num_requests   = 400;
  localparam int unsigned gnt_timeout    = 50;
  localparam logic [data_w-1:0] final_status = 32'h1234_5678;

  logic              clk;
  logic              rst_n;
  bus_req_t          core_req;
  bus_rsp_t          core_rsp;
  bus_req_t          periph_req;
  bus_req_t          stack_req;
  bus_req_t          tcdm_req;
  bus_rsp_t          periph_rsp;
  bus_rsp_t          stack_rsp;
  bus_rsp_t          tcdm_rsp;
  logic [data_w-1:0] status;
  logic              status_valid;
  logic [7:0]        char_out;
  logic              char_valid;
  int unsigned       check_count;
  int unsigned       error_count;
  int                seed;
  bus_req_t          next_req;

  tb_clock_gen #(
    .PERIOD ( 40 )
  ) i_clock_gen (
    .clk_o ( clk )
  );

  dbus_router #(
    .PERIPH_SEL_BIT ( periph_sel_bit )
  ) i_dut (
    .clk            ( clk          ),
    .rst_n          ( rst_n        ),
    .core_req_i     ( core_req     ),
    .core_rsp_o     ( core_rsp     ),
    .periph_req_o   ( periph_req   ),
    .periph_rsp_i   ( periph_rsp   ),
    .stack_req_o    ( stack_req    ),
    .stack_rsp_i    ( stack_rsp    ),
    .tcdm_req_o     ( tcdm_req     ),
    .tcdm_rsp_i     ( tcdm_rsp     ),
    .status_o       ( status       ),
    .status_valid_o ( status_valid ),
    .char_o         ( char_out     ),
    .char_valid_o   ( char_valid   )
  );

  dbus_router_checker #(
    .PERIPH_SEL_BIT ( periph_sel_bit )
  ) i_checker (
    .clk            ( clk          ),
    .rst_n          ( rst_n        ),
    .core_req_i     ( core_req     ),
    .core_rsp_i     ( core_rsp     ),
    .periph_req_i   ( periph_req   ),
    .periph_rsp_i   ( periph_rsp   ),
    .stack_req_i    ( stack_req    ),
    .stack_rsp_i    ( stack_rsp    ),
    .tcdm_req_i     ( tcdm_req     ),
    .tcdm_rsp_i     ( tcdm_rsp     ),
    .status_i       ( status       ),
    .status_valid_i ( status_valid ),
    .char_i         ( char_out     ),
    .char_valid_i   ( char_valid   ),
    .check_count_o  ( check_count  ),
    .error_count_o  ( error_count  )
  );

  // Each target grants 3 of 4 cycles and returns data 1 of 4 cycles
  task automatic randomize_targets();
    periph_rsp.gnt    = ($unsigned($random(seed)) % 4) != 0;
    periph_rsp.rvalid = ($unsigned($random(seed)) % 4) == 0;
    periph_rsp.rdata  = $random(seed);
    stack_rsp.gnt     = ($unsigned($random(seed)) % 4) != 0;
    stack_rsp.rvalid  = ($unsigned($random(seed)) % 4) == 0;
    stack_rsp.rdata   = $random(seed);
    tcdm_rsp.gnt      = ($unsigned($random(seed)) % 4) != 0;
    tcdm_rsp.rvalid   = ($unsigned($random(seed)) % 4) == 0;
    tcdm_rsp.rdata    = $random(seed);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
    randomize_targets();
  endtask

  // Region byte picks stack, mailbox or one of the two tcdm halves
  task automatic random_request(output bus_req_t req);
    int unsigned choice;
    choice   = $unsigned($random(seed)) % 4;
    req.req  = 1'b1;
    req.we   = $random(seed);
    req.be   = $random(seed);
    req.addr = $random(seed);
    req.wdata = $random(seed);
    case (choice)
      0: req.addr[region_lsb +: 8] = stack_region;
      1: req.addr[region_lsb +: 8] = mbox_region;
      2: req.addr[region_lsb +: 8] = 8'h01 + ($unsigned($random(seed)) % 8'h7f);
      default: req.addr[region_lsb +: 8] = 8'h81 + ($unsigned($random(seed)) % 8'h7f);
    endcase
    req.addr[periph_sel_bit] = $random(seed);
  endtask

  // Hold the request until the core sees the grant
  task automatic send_request(input bus_req_t req);
    int unsigned waited;
    logic        granted;
    waited   = 0;
    granted  = 1'b0;
    core_req = req;
    while (!granted && waited < gnt_timeout) begin
      @(negedge clk);
      granted = core_rsp.gnt;
      waited++;
      next_cycle();
    end
    if (!granted) begin
      $display("Timeout: request to address %h not granted within %0d cycles",
               req.addr, gnt_timeout);
      $display("*** FAILED ***");
      $finish;
    end
  endtask

  // Idle bus with a random payload, req stays low
  task automatic idle_cycle();
    core_req      = '0;
    core_req.addr = $random(seed);
    @(negedge clk);
    next_cycle();
  endtask

  task automatic mailbox_write(input addr_w_t addr, input logic [data_w-1:0] data);
    bus_req_t req;
    req.req   = 1'b1;
    req.we    = 1'b1;
    req.be    = '1;
    req.addr  = addr;
    req.wdata = data;
    send_request(req);
  endtask

  initial begin
    seed       = 32111;
    rst_n      = 1'b0;
    core_req   = '0;
    periph_rsp = '0;
    stack_rsp  = '0;
    tcdm_rsp   = '0;
    repeat (4) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;
    randomize_targets();
    repeat (2) idle_cycle();

    for (int unsigned i = 0; i < num_requests; i++) begin
      if (($unsigned($random(seed)) % 4) == 0) begin
        idle_cycle();
      end else begin
        random_request(next_req);
        send_request(next_req);
      end
    end

    // Report phase, as the core would at the end of a test program
    mailbox_write(mbox_status_addr, final_status);
    mailbox_write(mbox_char_addr, 32'h0000_004f);
    mailbox_write(mbox_char_addr, 32'h0000_004b);
    repeat (3) idle_cycle();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verification/dbus_router_checker.sv ====
// ########################################
// Router watcher: reference model of the
// routing rules, per-cycle compare, counts
// ########################################

module dbus_router_checker #(
  parameter int unsigned PERIPH_SEL_BIT = 20
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  bus_pkg::bus_req_t          core_req_i,
  input  bus_pkg::bus_rsp_t          core_rsp_i,
  input  bus_pkg::bus_req_t          periph_req_i,
  input  bus_pkg::bus_rsp_t          periph_rsp_i,
  input  bus_pkg::bus_req_t          stack_req_i,
  input  bus_pkg::bus_rsp_t          stack_rsp_i,
  input  bus_pkg::bus_req_t          tcdm_req_i,
  input  bus_pkg::bus_rsp_t          tcdm_rsp_i,
  input  logic [bus_pkg::data_w-1:0] status_i,
  input  logic                       status_valid_i,
  input  logic [7:0]                 char_i,
  input  logic                       char_valid_i,
  output int unsigned                check_count_o,
  output int unsigned                error_count_o
);

  import bus_pkg::*;
  import addr_map_pkg::*;

  typedef struct packed {
    bus_req_t periph;
    bus_req_t stack;
    bus_req_t tcdm;
    bus_rsp_t core;
  } expect_t;

  int unsigned       check_count = 0;
  int unsigned       error_count = 0;
  expect_t           exp;

  // Mailbox state as the rules predict it
  logic              exp_mbox_rvalid = 1'b0;
  logic [data_w-1:0] exp_status      = status_idle;
  logic              exp_status_valid = 1'b0;
  logic              exp_char_valid  = 1'b0;
  logic [7:0]        exp_char        = 8'h00;

  function automatic logic is_mbox_access(input bus_req_t req);
    return req.req && (req.addr[region_lsb +: 8] == mbox_region);
  endfunction

  // Expected target requests and core response for one cycle
  function automatic expect_t route_ref(input bus_req_t req, input bus_rsp_t p,
                                        input bus_rsp_t s, input bus_rsp_t t,
                                        input logic mbox_rv);
    expect_t    e;
    logic [7:0] region;
    logic       to_periph;
    logic       to_stack;
    logic       to_tcdm;
    region    = req.addr[region_lsb +: 8];
    to_periph = 1'b0;
    to_stack  = 1'b0;
    to_tcdm   = 1'b0;
    if (req.req && region != mbox_region) begin
      if (req.addr[PERIPH_SEL_BIT]) begin
        to_periph = 1'b1;
      end else if (region == stack_region) begin
        to_stack = 1'b1;
      end else begin
        to_tcdm = 1'b1;
      end
    end
    e.periph     = req;
    e.periph.req = to_periph;
    e.stack      = req;
    e.stack.req  = to_stack;
    e.tcdm       = req;
    e.tcdm.req   = to_tcdm;
    e.core.gnt   = to_periph ? p.gnt : to_stack ? s.gnt : to_tcdm ? t.gnt : 1'b1;
    e.core.rvalid = p.rvalid | s.rvalid | t.rvalid | mbox_rv;
    e.core.rdata = p.rvalid ? p.rdata : s.rvalid ? s.rdata : t.rvalid ? t.rdata : '0;
    return e;
  endfunction

  task automatic compare_value(input string name, input logic [69:0] got,
                               input logic [69:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("Error at %0t: %s expected %h got %h", $time, name, want, got);
    end
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      exp_mbox_rvalid  = 1'b0;
      exp_status       = status_idle;
      exp_status_valid = 1'b0;
      exp_char_valid   = 1'b0;
    end else begin
      exp = route_ref(core_req_i, periph_rsp_i, stack_rsp_i, tcdm_rsp_i, exp_mbox_rvalid);
      compare_value("periph_req_o", periph_req_i, exp.periph);
      compare_value("stack_req_o", stack_req_i, exp.stack);
      compare_value("tcdm_req_o", tcdm_req_i, exp.tcdm);
      compare_value("core_rsp_o.gnt", core_rsp_i.gnt, exp.core.gnt);
      compare_value("core_rsp_o.rvalid", core_rsp_i.rvalid, exp.core.rvalid);
      compare_value("core_rsp_o.rdata", core_rsp_i.rdata, exp.core.rdata);
      compare_value("status_o", status_i, exp_status);
      compare_value("status_valid_o", status_valid_i, exp_status_valid);
      compare_value("char_valid_o", char_valid_i, exp_char_valid);
      if (exp_char_valid) begin
        compare_value("char_o", char_i, exp_char);
      end
      // Predict the state for the next cycle
      exp_mbox_rvalid = is_mbox_access(core_req_i);
      exp_char_valid  = 1'b0;
      if (is_mbox_access(core_req_i) && core_req_i.we) begin
        if (core_req_i.addr == mbox_status_addr) begin
          exp_status       = core_req_i.wdata;
          exp_status_valid = 1'b1;
        end
        if (core_req_i.addr == mbox_char_addr) begin
          exp_char_valid = 1'b1;
          exp_char       = core_req_i.wdata[7:0];
        end
      end
    end
  end

  assign check_count_o = check_count;
  assign error_count_o = error_count;

endmodule

// ==== verification/tb_clock_gen.sv ====
// ########################################
// Testbench clock source
// ########################################

module tb_clock_gen #(
  parameter int unsigned PERIOD = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== source/dbus_router.sv ====
// ########################################
// Data-bus router top: decoder, response
// merge and test mailbox
// ########################################

module dbus_router #(
  parameter int unsigned PERIPH_SEL_BIT = 20
) (
  input  logic                       clk,
  input  logic                       rst_n,

  // Core data port
  input  bus_pkg::bus_req_t          core_req_i,
  output bus_pkg::bus_rsp_t          core_rsp_o,

  // Peripheral port
  output bus_pkg::bus_req_t          periph_req_o,
  input  bus_pkg::bus_rsp_t          periph_rsp_i,

  // Stack memory
  output bus_pkg::bus_req_t          stack_req_o,
  input  bus_pkg::bus_rsp_t          stack_rsp_i,

  // Shared data memory
  output bus_pkg::bus_req_t          tcdm_req_o,
  input  bus_pkg::bus_rsp_t          tcdm_rsp_i,

  // Mailbox outputs
  output logic [bus_pkg::data_w-1:0] status_o,
  output logic                       status_valid_o,
  output logic [7:0]                 char_o,
  output logic                       char_valid_o
);

  import bus_pkg::*;

  target_sel_t sel;
  logic        mbox_rvalid;

  region_decoder #(
    .PERIPH_SEL_BIT ( PERIPH_SEL_BIT )
  ) i_region_decoder (
    .core_req_i     ( core_req_i     ),
    .sel_o          ( sel            ),
    .periph_req_o   ( periph_req_o   ),
    .stack_req_o    ( stack_req_o    ),
    .tcdm_req_o     ( tcdm_req_o     )
  );

  response_merge i_response_merge (
    .sel_i          ( sel            ),
    .periph_rsp_i   ( periph_rsp_i   ),
    .stack_rsp_i    ( stack_rsp_i    ),
    .tcdm_rsp_i     ( tcdm_rsp_i     ),
    .mbox_rvalid_i  ( mbox_rvalid    ),
    .core_rsp_o     ( core_rsp_o     )
  );

  // Mailbox sees the core request directly, gated by its select bit
  test_mailbox i_test_mailbox (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .core_req_i     ( core_req_i     ),
    .mbox_sel_i     ( sel.mbox       ),
    .mbox_rvalid_o  ( mbox_rvalid    ),
    .status_o       ( status_o       ),
    .status_valid_o ( status_valid_o ),
    .char_o         ( char_o         ),
    .char_valid_o   ( char_valid_o   )
  );

endmodule

// ==== source/test_mailbox.sv ====
// ########################################
// Test mailbox: status word, printed
// characters and region read-valid
// ########################################

module test_mailbox (
  input  logic                        clk,
  input  logic                        rst_n,
  input  bus_pkg::bus_req_t           core_req_i,
  input  logic                        mbox_sel_i,
  output logic                        mbox_rvalid_o,
  output logic [bus_pkg::data_w-1:0]  status_o,
  output logic                        status_valid_o,
  output logic [7:0]                  char_o,
  output logic                        char_valid_o
);

  import bus_pkg::*;
  import addr_map_pkg::*;

  logic              mbox_hit;
  logic              status_wr;
  logic              char_wr;
  logic              rvalid_q;
  logic [data_w-1:0] status_q;
  logic              status_valid_q;
  logic [7:0]        char_q;
  logic              char_valid_q;

  assign mbox_hit  = core_req_i.req & mbox_sel_i;
  assign status_wr = mbox_hit & core_req_i.we & (core_req_i.addr == mbox_status_addr);
  assign char_wr   = mbox_hit & core_req_i.we & (core_req_i.addr == mbox_char_addr);

  // Answer every mailbox access one cycle later, reads and writes alike
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q       <= 1'b0;
      status_q       <= status_idle;
      status_valid_q <= 1'b0;
      char_valid_q   <= 1'b0;
    end else begin
      rvalid_q     <= mbox_hit;
      char_valid_q <= char_wr;
      if (status_wr) begin
        status_q       <= core_req_i.wdata;
        // Sticky once software has reported
        status_valid_q <= 1'b1;
      end
    end
  end

  // Character byte, qualified by char_valid_q
  always_ff @(posedge clk) begin
    if (char_wr) begin
      char_q <= core_req_i.wdata[7:0];
    end
  end

  assign mbox_rvalid_o  = rvalid_q;
  assign status_o       = status_q;
  assign status_valid_o = status_valid_q;
  assign char_o         = char_q;
  assign char_valid_o   = char_valid_q;

endmodule

// ==== source/response_merge.sv ====
// ########################################
// Merge of target grants, read data and
// read-valids into the core response
// ########################################

module response_merge (
  input  bus_pkg::target_sel_t sel_i,
  input  bus_pkg::bus_rsp_t    periph_rsp_i,
  input  bus_pkg::bus_rsp_t    stack_rsp_i,
  input  bus_pkg::bus_rsp_t    tcdm_rsp_i,
  input  logic                 mbox_rvalid_i,
  output bus_pkg::bus_rsp_t    core_rsp_o
);

  import bus_pkg::*;

  logic              core_gnt;
  logic              core_rvalid;
  logic [data_w-1:0] core_rdata;

  // Grant follows the selected target in the same cycle
  // Mailbox never stalls and an idle bus is always ready
  always_comb begin
    if (sel_i.periph) begin
      core_gnt = periph_rsp_i.gnt;
    end else if (sel_i.stack) begin
      core_gnt = stack_rsp_i.gnt;
    end else if (sel_i.tcdm) begin
      core_gnt = tcdm_rsp_i.gnt;
    end else begin
      core_gnt = 1'b1;
    end
  end

  // Read-valids are single-cycle pulses, any source answers the core
  assign core_rvalid = periph_rsp_i.rvalid
                     | stack_rsp_i.rvalid
                     | tcdm_rsp_i.rvalid
                     | mbox_rvalid_i;

  // Fixed priority periph > stack > tcdm
  // Mailbox returns no data, so rdata stays zero for it
  always_comb begin
    if (periph_rsp_i.rvalid) begin
      core_rdata = periph_rsp_i.rdata;
    end else if (stack_rsp_i.rvalid) begin
      core_rdata = stack_rsp_i.rdata;
    end else if (tcdm_rsp_i.rvalid) begin
      core_rdata = tcdm_rsp_i.rdata;
    end else begin
      core_rdata = '0;
    end
  end

  always_comb begin
    core_rsp_o.gnt    = core_gnt;
    core_rsp_o.rvalid = core_rvalid;
    core_rsp_o.rdata  = core_rdata;
  end

endmodule

// ==== source/region_decoder.sv ====
// ########################################
// Address region decoder and request
// fan-out to periph, stack and tcdm
// ########################################

module region_decoder #(
  parameter int unsigned PERIPH_SEL_BIT = 20
) (
  input  bus_pkg::bus_req_t    core_req_i,
  output bus_pkg::target_sel_t sel_o,
  output bus_pkg::bus_req_t    periph_req_o,
  output bus_pkg::bus_req_t    stack_req_o,
  output bus_pkg::bus_req_t    tcdm_req_o
);

  import bus_pkg::*;
  import addr_map_pkg::*;

  region_t     region;
  logic        periph_bit;
  target_sel_t sel;

  // Copy of the core request with req replaced by the target's select bit
  function automatic bus_req_t gate_req(input bus_req_t req_in, input logic en);
    bus_req_t req_out;
    req_out     = req_in;
    req_out.req = en;
    return req_out;
  endfunction

  assign region     = core_req_i.addr[region_lsb +: region_w];
  assign periph_bit = core_req_i.addr[PERIPH_SEL_BIT];

  // Region rule in priority order:
  // mailbox, then periph bit, then stack region, else tcdm
  always_comb begin
    sel = '0;
    if (core_req_i.req) begin
      if (region == mbox_region) begin
        sel.mbox = 1'b1;
      end else if (periph_bit) begin
        sel.periph = 1'b1;
      end else if (region == stack_region) begin
        sel.stack = 1'b1;
      end else begin
        sel.tcdm = 1'b1;
      end
    end
  end

  assign sel_o = sel;

  // All targets see the same payload, only the selected one gets req
  assign periph_req_o = gate_req(core_req_i, sel.periph);
  assign stack_req_o  = gate_req(core_req_i, sel.stack);
  assign tcdm_req_o   = gate_req(core_req_i, sel.tcdm);

endmodule

// ==== source/addr_map_pkg.sv ====
// ########################################
// Address map of the data bus: regions,
// mailbox offsets and status idle value
// ########################################

package addr_map_pkg;

  // Region byte sits in the top of the address
  localparam int unsigned region_lsb = 24;
  localparam int unsigned region_w   = bus_pkg::addr_w - region_lsb;

  typedef logic [region_w-1:0] region_t;

  // Stack memory lives in the lowest region
  localparam region_t stack_region = 8'h00;

  // Internal test mailbox
  localparam region_t mbox_region = 8'h80;

  // Mailbox registers
  localparam bus_pkg::addr_w_t mbox_status_addr = 32'h8000_0000;
  localparam bus_pkg::addr_w_t mbox_char_addr   = 32'h8000_0004;

  // Status before software has reported anything
  localparam logic [bus_pkg::data_w-1:0] status_idle = '1;

endpackage

// ==== source/bus_pkg.sv ====
// ########################################
// Core data-bus widths, request/response
// structs and the target-select vector
// ########################################

package bus_pkg;

  // Bus widths
  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;
  localparam int unsigned be_w   = data_w / 8;

  typedef logic [addr_w-1:0] addr_w_t;

  // Request from the core or to a target, 70 bits
  typedef struct packed {
    logic              req;
    logic              we;
    logic [be_w-1:0]   be;
    addr_w_t           addr;
    logic [data_w-1:0] wdata;
  } bus_req_t;

  // Response from a target or to the core, 34 bits
  // Grant belongs to the request phase, rvalid/rdata to the response phase
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [data_w-1:0] rdata;
  } bus_rsp_t;

  // One-hot target selection, all zero on an idle bus
  typedef struct packed {
    logic periph;
    logic stack;
    logic tcdm;
    logic mbox;
  } target_sel_t;

endpackage
